// ==== src/cl_msg_pkg.sv ====
`default_nettype none

package cl_msg_pkg;

  // host command and status word width
  localparam int MSG_W = 32;

  // one message word, same width in both directions
  typedef logic [MSG_W-1:0] msg_t;

  // command opcode values, found in the bits above the frame count
  localparam int OP_ARM = 1; // arm with count = frames to record

endpackage

`default_nettype wire

// ==== src/cl_link_pkg.sv ====
`default_nettype none

package cl_link_pkg;

  // camera timing counters
  localparam int LINE_W = 12; // lines per frame
  localparam int CLK_W  = 10; // pixels per line
  localparam int FULL_W = 2;  // full cycles, wraps

  localparam int SLOT_W = 2;

  // status word format rotates 0, 2, 1 within a line
  typedef enum logic [SLOT_W-1:0] {
    SLOT_0 = 2'd0,
    SLOT_1 = 2'd1, // carries fval, lval and the full count
    SLOT_2 = 2'd2
  } slot_t;

  // top four bits of every status word
  typedef struct packed {
    slot_t slot;
    logic  first_frame; // still in the first captured frame
    logic  first_line;  // line count is zero
  } header_t;

endpackage

`default_nettype wire

// ==== src/cl_timing_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface cl_timing_if;

  logic fval;        // frame valid as sampled
  logic lval;        // line valid as sampled
  logic fval_d;
  logic lval_d;
  logic frame_start; // rising fval

  logic [cl_link_pkg::LINE_W-1:0] n_line;
  logic [cl_link_pkg::CLK_W-1:0]  n_clk;
  logic [cl_link_pkg::FULL_W-1:0] n_full;

  // line timer owns every signal
  modport source (
    output fval, lval, fval_d, lval_d, frame_start, n_line, n_clk, n_full
  );

  // control only needs the frame boundary
  modport ctrl (
    input frame_start
  );

  modport packer (
    input lval, lval_d, fval, n_line, n_clk, n_full
  );

endinterface

`default_nettype wire

// ==== src/cl_line_timer.sv ====
`timescale 1ns/100ps
`default_nettype none

module cl_line_timer (
  input  wire logic   reset,
  input  wire logic   bus_clk,
  input  wire logic   cl_fval,
  input  wire logic   cl_lval,
  input  wire logic   fpga_msg_full,
  input  wire logic   capturing,
  cl_timing_if.source timing
);

  logic line_start;

  // levels pass straight through so valid has no latency
  assign timing.fval = cl_fval;
  assign timing.lval = cl_lval;

  assign timing.frame_start = timing.fval && !timing.fval_d;
  assign line_start         = timing.lval && !timing.lval_d;

  always_ff @(posedge reset or posedge bus_clk) begin
    if (bus_clk) begin
      timing.fval_d <= 1'b0;
      timing.lval_d <= 1'b0;
      timing.n_clk  <= '0;
      timing.n_line <= '0;
      timing.n_full <= '0;
    end else begin
      timing.fval_d <= timing.fval;
      timing.lval_d <= timing.lval;

      // pixel count restarts whenever lval drops
      timing.n_clk <= timing.lval ? timing.n_clk + 1'b1 : '0;

      // line count steps at each line start and the first line of a frame is 0
      if (line_start) begin
        timing.n_line <= timing.fval_d ? timing.n_line + 1'b1 : '0;
      end

      // consecutive full cycles only while recording
      if (capturing && fpga_msg_full) begin
        timing.n_full <= timing.n_full + 1'b1;
      end else begin
        timing.n_full <= '0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/cl_capture_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module cl_capture_ctrl #(
  parameter int FRAME_W = 20
) (
  input  wire logic              reset,
  input  wire logic              bus_clk,
  input  wire logic              pc_msg_pending,
  input  wire cl_msg_pkg::msg_t  pc_msg,
  output logic                   pc_msg_ack,
  output logic                   cl_done,
  output logic                   capturing,
  output logic                   first_frame,
  cl_timing_if.ctrl              timing
);

  localparam int OP_W = cl_msg_pkg::MSG_W - FRAME_W;

  typedef enum logic [1:0] {
    ST_STANDBY,
    ST_ARMED,
    ST_CAPTURING
  } state_t;

  state_t             state;
  logic [OP_W-1:0]    opcode;
  logic [FRAME_W-1:0] count;
  logic [FRAME_W-1:0] frame_req;   // requested frames
  logic [FRAME_W-1:0] frames_left;
  logic               accept;
  logic               arm_cmd;

  assign opcode = pc_msg[cl_msg_pkg::MSG_W-1:FRAME_W];
  assign count  = pc_msg[FRAME_W-1:0];

  // new command only taken in standby with one ack per pending strobe
  assign accept  = (state == ST_STANDBY) && pc_msg_pending && !pc_msg_ack;
  assign arm_cmd = (opcode == OP_W'(cl_msg_pkg::OP_ARM)) && (count != '0);

  assign capturing   = (state == ST_CAPTURING);
  assign first_frame = capturing && (frames_left == frame_req); // nothing counted down yet

  always_ff @(posedge reset) begin
    if (accept && arm_cmd) begin
      frame_req <= count;
    end
  end

  always_ff @(posedge reset or posedge bus_clk) begin
    if (bus_clk) begin
      state       <= ST_STANDBY;
      frames_left <= '0;
      pc_msg_ack  <= 1'b0;
      cl_done     <= 1'b0;
    end else begin
      pc_msg_ack <= 1'b0; // both strobes last one cycle
      cl_done    <= 1'b0;

      case (state)
        ST_STANDBY: begin
          if (accept) begin
            pc_msg_ack <= 1'b1;
            if (arm_cmd) begin
              state <= ST_ARMED;
            end
          end
        end
        ST_ARMED: begin
          // wait for a clean frame boundary
          if (timing.frame_start) begin
            frames_left <= frame_req;
            state       <= ST_CAPTURING;
          end
        end
        ST_CAPTURING: begin
          if (timing.frame_start) begin
            frames_left <= frames_left - 1'b1;
            if (frames_left == FRAME_W'(1)) begin
              state   <= ST_STANDBY; // last requested frame has ended
              cl_done <= 1'b1;
            end
          end
        end
        default: state <= ST_STANDBY;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/cl_word_packer.sv ====
`timescale 1ns/100ps
`default_nettype none

module cl_word_packer (
  input  wire logic        reset,
  input  wire logic        bus_clk,
  input  wire logic        capturing,
  input  wire logic        first_frame,
  cl_timing_if.packer      timing,
  output cl_msg_pkg::msg_t fpga_msg,
  output logic             fpga_msg_valid
);

  cl_link_pkg::slot_t   slot;
  cl_link_pkg::header_t header;

  // rotation 0, 2, 1, back to 0 after each line
  always_ff @(posedge reset or posedge bus_clk) begin
    if (bus_clk) begin
      slot <= cl_link_pkg::SLOT_0;
    end else if (!timing.lval_d) begin
      slot <= cl_link_pkg::SLOT_0;
    end else begin
      case (slot)
        cl_link_pkg::SLOT_0: slot <= cl_link_pkg::SLOT_2;
        cl_link_pkg::SLOT_2: slot <= cl_link_pkg::SLOT_1;
        default:             slot <= cl_link_pkg::SLOT_0;
      endcase
    end
  end

  assign header.slot        = slot;
  assign header.first_frame = first_frame;
  assign header.first_line  = (timing.n_line == '0);

  always_comb begin
    if (slot == cl_link_pkg::SLOT_1) begin
      fpga_msg = {header, timing.fval, timing.lval, timing.n_full,
                  timing.n_line, 2'b00, timing.n_clk};
    end else begin
      fpga_msg = {header, 4'h0, timing.n_line, 2'b00, timing.n_clk};
    end
  end

  // lval_d keeps the word after the line's last pixel
  assign fpga_msg_valid = capturing && (timing.lval || timing.lval_d);

endmodule

`default_nettype wire

// ==== src/cl_capture_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module cl_capture_top #(
  parameter int FRAME_W = 20 // frame count field, 8 to 28
) (
  input  wire logic                         reset,
  input  wire logic                         bus_clk,
  input  wire logic                         pc_msg_pending,
  input  wire logic [cl_msg_pkg::MSG_W-1:0] pc_msg,
  input  wire logic                         fpga_msg_full,
  input  wire logic                         cl_fval,
  input  wire logic                         cl_lval,
  output logic                              pc_msg_ack,
  output logic      [cl_msg_pkg::MSG_W-1:0] fpga_msg,
  output logic                              fpga_msg_valid,
  output logic                              cl_done,
  output logic      [2:0]                   led
);

  logic capturing;
  logic first_frame;

  cl_timing_if timing_if_i ();

  cl_line_timer timer_i (
    .reset         (reset),
    .bus_clk       (bus_clk),
    .cl_fval       (cl_fval),
    .cl_lval       (cl_lval),
    .fpga_msg_full (fpga_msg_full),
    .capturing     (capturing),
    .timing        (timing_if_i.source)
  );

  cl_capture_ctrl #(
    .FRAME_W (FRAME_W)
  ) ctrl_i (
    .reset          (reset),
    .bus_clk        (bus_clk),
    .pc_msg_pending (pc_msg_pending),
    .pc_msg         (pc_msg),
    .pc_msg_ack     (pc_msg_ack),
    .cl_done        (cl_done),
    .capturing      (capturing),
    .first_frame    (first_frame),
    .timing         (timing_if_i.ctrl)
  );

  cl_word_packer packer_i (
    .reset          (reset),
    .bus_clk        (bus_clk),
    .capturing      (capturing),
    .first_frame    (first_frame),
    .timing         (timing_if_i.packer),
    .fpga_msg       (fpga_msg),
    .fpga_msg_valid (fpga_msg_valid)
  );

  // status lights for backpressure, word out and frame active
  assign led = {fpga_msg_full, fpga_msg_valid, cl_fval};

endmodule

`default_nettype wire

// ==== tb/cl_capture_properties.sv ====
`timescale 1ns/100ps
`default_nettype none

module cl_capture_properties (
  input wire logic reset,
  input wire logic bus_clk,
  input wire logic pc_msg_ack,
  input wire logic cl_done,
  input wire logic fpga_msg_valid,
  input wire logic capturing
);

  ack_single_cycle: assert property (
    @(posedge reset) disable iff (bus_clk) pc_msg_ack |=> !pc_msg_ack
  ) else $error("pc_msg_ack held for two cycles");

  done_single_cycle: assert property (
    @(posedge reset) disable iff (bus_clk) cl_done |=> !cl_done
  ) else $error("cl_done held for two cycles");

  // words only leave while a capture runs
  valid_while_capturing: assert property (
    @(posedge reset) disable iff (bus_clk) fpga_msg_valid |-> capturing
  ) else $error("fpga_msg_valid high outside a capture");

endmodule

bind cl_capture_top cl_capture_properties props_i (
  .reset          (reset),
  .bus_clk        (bus_clk),
  .pc_msg_ack     (pc_msg_ack),
  .cl_done        (cl_done),
  .fpga_msg_valid (fpga_msg_valid),
  .capturing      (capturing)
);

`default_nettype wire

// ==== tb/tb_cl_capture.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_cl_capture;

  localparam int FRAME_W = 20;
  localparam int OP_W    = cl_msg_pkg::MSG_W - FRAME_W;
  localparam int MAX_REC = 16;

  logic        reset;   // clock
  logic        bus_clk; // async reset
  logic        pc_msg_pending;
  logic [31:0] pc_msg;
  logic        fpga_msg_full;
  logic        cl_fval;
  logic        cl_lval;
  logic        pc_msg_ack;
  logic [31:0] fpga_msg;
  logic        fpga_msg_valid;
  logic        cl_done;
  logic [2:0]  led;

  int          rec [MAX_REC][10]; // one row per data file record
  int          n_rec;
  int          full_mode;
  logic [31:0] rng;
  int          n_ack;
  int          n_done;
  int          n_valid;

  // reference model
  logic [1:0]                     m_state; // 0 standby, 1 armed, 2 capturing
  logic [FRAME_W-1:0]             m_frame_req;
  logic [FRAME_W-1:0]             m_frames_left;
  logic                           m_counted;
  logic                           m_ack;
  logic                           m_done;
  logic                           m_fval_d;
  logic                           m_lval_d;
  logic [1:0]                     m_slot;
  logic [cl_link_pkg::LINE_W-1:0] m_n_line;
  logic [cl_link_pkg::CLK_W-1:0]  m_n_clk;
  logic [cl_link_pkg::FULL_W-1:0] m_n_full;

  cl_capture_top #(
    .FRAME_W (FRAME_W)
  ) dut_i (
    .reset          (reset),
    .bus_clk        (bus_clk),
    .pc_msg_pending (pc_msg_pending),
    .pc_msg         (pc_msg),
    .fpga_msg_full  (fpga_msg_full),
    .cl_fval        (cl_fval),
    .cl_lval        (cl_lval),
    .pc_msg_ack     (pc_msg_ack),
    .fpga_msg       (fpga_msg),
    .fpga_msg_valid (fpga_msg_valid),
    .cl_done        (cl_done),
    .led            (led)
  );

  initial begin
    reset = 1'b0;
    forever #4 reset = ~reset;
  end

  task automatic fail_run();
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
      fail_run();
    end
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] expected_word();
    logic [3:0] hdr;
    hdr = {m_slot, (m_state == 2'd2) && !m_counted, m_n_line == '0};
    if (m_slot == 2'd1) begin
      return {hdr, cl_fval, cl_lval, m_n_full, m_n_line, 2'b00, m_n_clk};
    end
    return {hdr, 4'h0, m_n_line, 2'b00, m_n_clk};
  endfunction

  task automatic compare_outputs();
    logic exp_valid;
    exp_valid = (m_state == 2'd2) && (cl_lval || m_lval_d);
    check("pc_msg_ack", pc_msg_ack, m_ack);
    check("cl_done", cl_done, m_done);
    check("fpga_msg_valid", fpga_msg_valid, exp_valid);
    check("led", led, {fpga_msg_full, exp_valid, cl_fval});
    if (exp_valid) begin
      check("fpga_msg", fpga_msg, expected_word());
    end
    n_ack   += pc_msg_ack;
    n_done  += cl_done;
    n_valid += fpga_msg_valid;
  endtask

  // next model state from the levels seen during this cycle
  task automatic advance_model();
    logic               capt;
    logic               accept;
    logic               frame_start;
    logic [OP_W-1:0]    opcode;
    logic [FRAME_W-1:0] count;
    capt        = (m_state == 2'd2);
    accept      = (m_state == 2'd0) && pc_msg_pending && !m_ack;
    frame_start = cl_fval && !m_fval_d;
    opcode      = pc_msg[31:FRAME_W];
    count       = pc_msg[FRAME_W-1:0];
    m_ack       = accept;
    m_done      = 1'b0;
    case (m_state)
      2'd0: begin
        if (accept && opcode == OP_W'(1) && count != '0) begin
          m_state     = 2'd1;
          m_frame_req = count;
        end
      end
      2'd1: begin
        if (frame_start) begin
          m_frames_left = m_frame_req;
          m_counted     = 1'b0;
          m_state       = 2'd2;
        end
      end
      2'd2: begin
        if (frame_start) begin
          m_counted = 1'b1;
          if (m_frames_left == FRAME_W'(1)) begin
            m_state = 2'd0;
            m_done  = 1'b1;
          end
          m_frames_left = m_frames_left - 1'b1;
        end
      end
      default: m_state = 2'd0;
    endcase
    m_n_clk = cl_lval ? m_n_clk + 1'b1 : '0;
    if (cl_lval && !m_lval_d) begin
      m_n_line = m_fval_d ? m_n_line + 1'b1 : '0; // restarts on a line at frame start
    end
    m_n_full = (capt && fpga_msg_full) ? m_n_full + 1'b1 : '0;
    if (!m_lval_d) begin
      m_slot = 2'd0;
    end else begin
      m_slot = (m_slot == 2'd0) ? 2'd2 : m_slot - 1'b1;
    end
    m_fval_d = cl_fval;
    m_lval_d = cl_lval;
  endtask

  // called 1 ns after a rising edge
  task automatic run_cycle(input logic fval, input logic lval);
    cl_fval = fval;
    cl_lval = lval;
    if (full_mode == 2) begin
      rng           = lcg_next(rng);
      fpga_msg_full = rng[16];
    end else begin
      fpga_msg_full = (full_mode == 1);
    end
    @(negedge reset);
    compare_outputs();
    @(posedge reset);
    advance_model();
    #1;
  endtask

  task automatic drive_frame(input int lines, input int pixels, input int gap);
    for (int l = 0; l < lines; l++) begin
      repeat (pixels) run_cycle(1'b1, 1'b1);
      repeat (gap) run_cycle(1'b1, 1'b0);
    end
    repeat (gap) run_cycle(1'b0, 1'b0);
  endtask

  task automatic send_command(input logic [31:0] cmd);
    pc_msg         = cmd;
    pc_msg_pending = 1'b1;
    while (pc_msg_ack !== 1'b1) begin
      run_cycle(1'b0, 1'b0);
    end
    pc_msg_pending = 1'b0; // host drops the request once acked
    pc_msg         = '0;
    run_cycle(1'b0, 1'b0);
  endtask

  task automatic load_records();
    int    fd;
    int    n;
    string line;
    fd = $fopen("tb/cl_capture_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open the test data file tb/cl_capture_testdata.txt");
      fail_run();
    end
    n_rec = 0;
    while (!$feof(fd) && n_rec < MAX_REC) begin
      line = "";
      n    = $fgets(line, fd);
      if (line.len() < 2 || line[0] == "#") begin
        continue;
      end
      n = $sscanf(line, "%h %d %d %d %d %d %d %d %d %d", rec[n_rec][0], rec[n_rec][1],
                  rec[n_rec][2], rec[n_rec][3], rec[n_rec][4], rec[n_rec][5],
                  rec[n_rec][6], rec[n_rec][7], rec[n_rec][8], rec[n_rec][9]);
      if (n != 10) begin
        $display("test data record %0d has %0d fields instead of 10", n_rec, n);
        fail_run();
      end
      n_rec++;
    end
    $fclose(fd);
  endtask

  task automatic watchdog(input longint cycles);
    #(cycles * 8);
    $display("simulation timed out at %0t with the DUT still busy", $time);
    fail_run();
  endtask

  task automatic run_record(input int i);
    full_mode = rec[i][6];
    n_ack     = 0;
    n_done    = 0;
    n_valid   = 0;
    repeat (rec[i][1]) drive_frame(rec[i][3], rec[i][4], rec[i][5]);
    send_command(rec[i][0]);
    repeat (rec[i][2]) drive_frame(rec[i][3], rec[i][4], rec[i][5]);
    repeat (2) run_cycle(1'b0, 1'b0);
    check("ack count", n_ack, rec[i][7]);
    check("done count", n_done, rec[i][8]);
    check("valid word count", n_valid, rec[i][9]);
  endtask

  initial begin
    longint limit;
    bus_clk        = 1'b1;
    pc_msg_pending = 1'b0;
    pc_msg         = '0;
    fpga_msg_full  = 1'b0;
    cl_fval        = 1'b0;
    cl_lval        = 1'b0;
    full_mode      = 0;
    rng            = 32'h7558_5fca;
    m_state        = 2'd0;
    m_frame_req    = '0;
    m_frames_left  = '0;
    m_counted      = 1'b0;
    m_ack          = 1'b0;
    m_done         = 1'b0;
    m_fval_d       = 1'b0;
    m_lval_d       = 1'b0;
    m_slot         = 2'd0;
    m_n_line       = '0;
    m_n_clk        = '0;
    m_n_full       = '0;
    load_records();
    limit = 210; // reset plus margin
    for (int i = 0; i < n_rec; i++) begin
      limit += (rec[i][1] + rec[i][2]) * (rec[i][3] * (rec[i][4] + rec[i][5]) + rec[i][5]) + 8;
    end
    fork
      watchdog(limit);
    join_none
    repeat (10) @(posedge reset);
    #1;
    bus_clk = 1'b0;
    for (int i = 0; i < n_rec; i++) begin
      run_record(i);
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== cl_capture.f ====
src/cl_msg_pkg.sv
src/cl_link_pkg.sv
src/cl_timing_if.sv
src/cl_line_timer.sv
src/cl_capture_ctrl.sv
src/cl_word_packer.sv
src/cl_capture_top.sv
tb/cl_capture_properties.sv
tb/tb_cl_capture.sv

// ==== Bender.yml ====
package:
  name: cl_capture

sources:
  - src/cl_msg_pkg.sv
  - src/cl_link_pkg.sv
  - src/cl_timing_if.sv
  - src/cl_line_timer.sv
  - src/cl_capture_ctrl.sv
  - src/cl_word_packer.sv
  - src/cl_capture_top.sv
  - target: test
    files:
      - tb/cl_capture_properties.sv
      - tb/tb_cl_capture.sv

// ==== tb/cl_capture_testdata.txt ====
# cmd idle_frames frames lines pixels gap full_mode acks dones words
# full_mode 0 never, 1 always, 2 lcg bit; an arm for N frames needs N+1 frames driven
00200005 1 2 2 4 2 0 1 0 0
00100000 0 2 2 3 1 1 1 0 0
00100002 1 3 3 5 2 0 1 1 36
00100001 0 2 4 7 3 1 1 1 32
00100003 2 4 2 9 1 2 1 1 60
00100001 0 2 5 1 1 2 1 1 10
